/* design/bram.sv */
/*
 * Single-port block RAM of 32-bit words with byte-lane write enables.
 * Read is registered and returns the old word during a write.
 */
`timescale 1ns/1ps

module bram #(
  parameter int unsigned line_index_width = 8
) (
  input  logic                        clk,
  input  logic [line_index_width-1:0] address,
  input  logic [3:0]                  write_enable,
  input  logic [31:0]                 data_in,
  output logic [31:0]                 data_out
);

  logic [31:0] mem [2 ** line_index_width];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (write_enable[i]) begin
        mem[address][8*i +: 8] <= data_in[8*i +: 8];
      end
    end
    // read before write
    data_out <= mem[address];
  end

endmodule

/* design/burst_ctrl.sv */
/*
 * Cache controller: lookup handshake, line refill, dirty eviction and
 * spacing of burst commands. A request counts as looked up once its
 * address has been held for two cycles, matching the registered RAM reads.
 */
`timescale 1ns/1ps

module burst_ctrl #(
  parameter int unsigned line_index_width = 8,
  parameter int unsigned ram_addr_width = 21,
  parameter int unsigned cmd_interval = 13
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  cache_pkg::cpu_req_t       req,
  input  logic                      hit,
  input  logic                      dirty,
  input  logic                      clearing,
  input  logic [29:0]               victim_tag,
  output logic                      fill_done,
  output logic                      hit_write,
  output logic                      fill,
  output logic [1:0]                beat,
  output logic [63:0]               fill_data,
  input  logic [63:0]               beat_data,
  output logic                      busy,
  output logic                      data_out_ready,
  output cache_pkg::br_req_t        br_req,
  output logic [ram_addr_width-1:0] br_addr,
  input  logic [63:0]               br_rd_data,
  input  logic                      br_rd_data_valid
);
  import cache_pkg::*;

  localparam int unsigned line_shift = column_bits + zero_bits;
  localparam int unsigned tag_width = ram_addr_width - line_index_width - line_shift;
  localparam int unsigned cnt_width = $clog2(cmd_interval + 2);

  typedef enum logic [3:0] {
    st_idle, st_write1, st_write2, st_write3, st_wait_interval,
    st_wait_read, st_read1, st_read2, st_read3, st_tag_update, st_finish
  } state_e;

  state_e                    state;
  logic [cnt_width-1:0]      cmd_count;
  logic                      cmd_q;
  logic                      cmd_en_q;
  logic [63:0]               wr_data_q;
  logic                      req_seen;
  logic [31:0]               req_addr_q;
  logic                      lookup;
  logic                      start_miss;
  logic                      start_refill;
  logic [ram_addr_width-1:0] victim_addr;
  logic [ram_addr_width-1:0] refill_addr;

  // RAM outputs belong to this address only after it was held a cycle
  assign lookup = req.en && req_seen && req_addr_q == req.addr && !clearing;
  assign start_miss   = state == st_idle && lookup && !hit && cmd_count == '0;
  assign start_refill = state == st_wait_interval && cmd_count == '0;

  assign refill_addr = {req.addr[ram_addr_width-1:line_shift], {line_shift{1'b0}}};
  assign victim_addr = {victim_tag[tag_width-1:0],
                        req.addr[line_index_width+line_shift-1:line_shift],
                        {line_shift{1'b0}}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      cmd_count <= '0;
      cmd_q     <= 1'b0;
      cmd_en_q  <= 1'b0;
      req_seen  <= 1'b0;
    end else begin
      cmd_en_q <= 1'b0;
      req_seen <= req.en && !clearing;
      if (cmd_count != '0) cmd_count <= cmd_count - 1'b1;
      if (start_miss || start_refill) begin
        cmd_en_q  <= 1'b1;
        cmd_count <= cnt_width'(cmd_interval);
        cmd_q     <= start_miss && dirty;
      end
      case (state)
        st_idle:
          if (start_miss) state <= dirty ? st_write1 : st_wait_read;
        st_write1:        state <= st_write2;
        st_write2:        state <= st_write3;
        st_write3:        state <= st_wait_interval;
        st_wait_interval: if (start_refill) state <= st_wait_read;
        st_wait_read:     if (br_rd_data_valid) state <= st_read1;
        st_read1:         state <= st_read2;
        st_read2:         state <= st_read3;
        st_read3:         state <= st_tag_update;
        st_tag_update:    state <= st_finish;
        default:          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    req_addr_q <= req.addr;
    if (start_miss && dirty) br_addr <= victim_addr;
    else if (start_miss || start_refill) br_addr <= refill_addr;
    // beat 0 leaves with the command and the rest follow one per cycle
    if (start_miss || state inside {st_write1, st_write2, st_write3}) wr_data_q <= beat_data;
  end

  always_comb begin
    case (state)
      st_write1, st_read1: beat = 2'd1;
      st_write2, st_read2: beat = 2'd2;
      st_write3, st_read3: beat = 2'd3;
      default:             beat = 2'd0;
    endcase
  end

  assign fill = (state == st_wait_read && br_rd_data_valid) ||
                state inside {st_read1, st_read2, st_read3};
  assign fill_data = br_rd_data;
  assign fill_done = state == st_tag_update;
  assign hit_write = state == st_idle && lookup && hit && req.wr_en != 4'b0000;
  assign data_out_ready = state == st_idle && lookup && hit && req.wr_en == 4'b0000;
  assign busy = clearing || state != st_idle || (lookup && !hit);

  always_comb begin
    br_req.cmd       = cmd_q;
    br_req.cmd_en    = cmd_en_q;
    br_req.wr_data   = wr_data_q;
    br_req.data_mask = 8'h00;
  end

  assert property (@(posedge clk) disable iff (!rst_n) br_req.cmd_en |=> !br_req.cmd_en);
  // a command only leaves after the previous interval has run out
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(br_req.cmd_en) |-> $past(cmd_count) == '0);

endmodule

/* design/cache_pkg.sv */
/*
 * Shared constants and types for the direct-mapped write-back cache.
 * Modules import this package inside their bodies and name its types
 * with scoped names in their port lists.
 */
package cache_pkg;

  // word aligned accesses ignore the two low address bits
  localparam int unsigned zero_bits = 2;
  localparam int unsigned column_bits = 3;
  localparam int unsigned column_count = 2 ** column_bits;
  localparam int unsigned beat_count = 4;

  // flags on top and tag bits above the parameter tag width kept at zero
  typedef struct packed {
    logic        dirty;
    logic        valid;
    logic [29:0] tag;
  } tag_entry_t;

  // the tag RAM stores the raw word and the logic reads the entry view
  typedef union packed {
    logic [31:0] raw;
    tag_entry_t  entry;
  } tag_word_u;

  typedef struct packed {
    logic        en;
    logic [31:0] addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_en;
  } cpu_req_t;

  typedef struct packed {
    logic        cmd;
    logic        cmd_en;
    logic [63:0] wr_data;
    logic [7:0]  data_mask;
  } br_req_t;

endpackage

/* design/cache_top.sv */
/*
 * Direct-mapped write-back cache between a 32-bit processor port and a
 * 64-bit burst PSRAM controller. Splits the byte address into tag, line
 * and column and connects the tag store, line store and controller.
 */
`timescale 1ns/1ps

module cache_top #(
  parameter int unsigned line_index_width = 8,
  parameter int unsigned ram_addr_width = 21,
  parameter int unsigned cmd_interval = 13
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  cache_pkg::cpu_req_t       req,
  output logic [31:0]               data_out,
  output logic                      data_out_ready,
  output logic                      busy,
  output cache_pkg::br_req_t        br_req,
  output logic [ram_addr_width-1:0] br_addr,
  input  logic [63:0]               br_rd_data,
  input  logic                      br_rd_data_valid
);
  import cache_pkg::*;

  localparam int unsigned line_shift = column_bits + zero_bits;
  localparam int unsigned tag_width = ram_addr_width - line_index_width - line_shift;

  // |tag|line|col|00|
  logic [column_bits-1:0]      column_index;
  logic [line_index_width-1:0] line_index;
  logic [29:0]                 address_tag;
  logic                        hit;
  logic                        dirty;
  logic                        clearing;
  logic                        fill_done;
  logic                        hit_write;
  logic                        fill;
  logic [29:0]                 victim_tag;
  logic [1:0]                  beat;
  logic [63:0]                 fill_data;
  logic [63:0]                 beat_data;
  logic [3:0]                  cpu_write_enable;

  assign column_index = req.addr[line_shift-1:zero_bits];
  assign line_index   = req.addr[line_index_width+line_shift-1:line_shift];
  assign address_tag  = 30'(req.addr[ram_addr_width-1 -: tag_width]);
  assign cpu_write_enable = hit_write ? req.wr_en : 4'b0000;

  tag_store #(
    .line_index_width(line_index_width)
  ) tag_store0 (
    .clk(clk), .rst_n(rst_n), .line_index(line_index), .address_tag(address_tag),
    .fill_done(fill_done), .hit_write(hit_write), .hit(hit), .dirty(dirty),
    .victim_tag(victim_tag), .clearing(clearing)
  );

  line_store #(
    .line_index_width(line_index_width)
  ) line_store0 (
    .clk(clk), .line_index(line_index), .column_index(column_index),
    .cpu_write_enable(cpu_write_enable), .cpu_data(req.wr_data), .fill(fill),
    .beat(beat), .fill_data(fill_data), .word(data_out), .beat_data(beat_data)
  );

  burst_ctrl #(
    .line_index_width(line_index_width),
    .ram_addr_width  (ram_addr_width),
    .cmd_interval    (cmd_interval)
  ) burst_ctrl0 (
    .clk(clk), .rst_n(rst_n), .req(req), .hit(hit), .dirty(dirty), .clearing(clearing),
    .victim_tag(victim_tag), .fill_done(fill_done), .hit_write(hit_write), .fill(fill),
    .beat(beat), .fill_data(fill_data), .beat_data(beat_data), .busy(busy),
    .data_out_ready(data_out_ready), .br_req(br_req), .br_addr(br_addr),
    .br_rd_data(br_rd_data), .br_rd_data_valid(br_rd_data_valid)
  );

endmodule

/* design/line_store.sv */
/*
 * Data store of one cache line per index, split over eight column RAMs.
 * Burst fills write a pair of columns per beat; processor writes hit a
 * single column. Outputs the addressed word and a beat pair for eviction.
 */
`timescale 1ns/1ps

module line_store #(
  parameter int unsigned line_index_width = 8
) (
  input  logic                           clk,
  input  logic [line_index_width-1:0]    line_index,
  input  logic [cache_pkg::column_bits-1:0] column_index,
  input  logic [3:0]                     cpu_write_enable,
  input  logic [31:0]                    cpu_data,
  input  logic                           fill,
  input  logic [1:0]                     beat,
  input  logic [63:0]                    fill_data,
  output logic [31:0]                    word,
  output logic [63:0]                    beat_data
);
  import cache_pkg::*;

  logic [3:0]  column_we   [column_count];
  logic [31:0] column_din  [column_count];
  logic [31:0] column_dout [column_count];
  logic [63:0] beat_pair   [beat_count];

  always_comb begin
    for (int i = 0; i < column_count; i++) begin
      column_we[i]  = 4'b0000;
      column_din[i] = cpu_data;
      if (fill) begin
        // even column takes the low half of the beat
        column_din[i] = (i % 2 == 1) ? fill_data[63:32] : fill_data[31:0];
        if (i / 2 == int'(beat)) column_we[i] = 4'b1111;
      end else if (i == int'(column_index)) begin
        column_we[i] = cpu_write_enable;
      end
    end
  end

  for (genvar i = 0; i < column_count; i++) begin : g_column
    bram #(
      .line_index_width(line_index_width)
    ) column_ram (
      .clk         (clk),
      .address     (line_index),
      .write_enable(column_we[i]),
      .data_in     (column_din[i]),
      .data_out    (column_dout[i])
    );
  end

  for (genvar b = 0; b < beat_count; b++) begin : g_beat
    assign beat_pair[b] = {column_dout[2*b+1], column_dout[2*b]};
  end

  assign word      = column_dout[column_index];
  assign beat_data = beat_pair[beat];

  // the controller only refills outside the idle state
  assert property (@(posedge clk) !(fill && cpu_write_enable != 4'b0000));

endmodule

/* design/tag_store.sv */
/*
 * Tag RAM with valid and dirty flags, hit detection and a clear sweep.
 * After reset every line is written to zero once; clearing stays high
 * for the whole sweep so the controller can hold off the processor.
 */
`timescale 1ns/1ps

module tag_store #(
  parameter int unsigned line_index_width = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [line_index_width-1:0] line_index,
  input  logic [29:0]                 address_tag,
  input  logic                        fill_done,
  input  logic                        hit_write,
  output logic                        hit,
  output logic                        dirty,
  output logic [29:0]                 victim_tag,
  output logic                        clearing
);
  import cache_pkg::*;

  logic [line_index_width-1:0] sweep_index;
  logic [line_index_width-1:0] ram_address;
  logic [3:0]                  ram_write_enable;
  tag_word_u                   rd_word;
  tag_word_u                   wr_word;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clearing    <= 1'b1;
      sweep_index <= '0;
    end else if (clearing) begin
      sweep_index <= sweep_index + 1'b1;
      if (sweep_index == '1) clearing <= 1'b0;
    end
  end

  always_comb begin
    wr_word.entry.dirty = hit_write;
    wr_word.entry.valid = 1'b1;
    wr_word.entry.tag   = address_tag;
    if (clearing) wr_word.raw = '0;
  end

  assign ram_address      = clearing ? sweep_index : line_index;
  assign ram_write_enable = (clearing || fill_done || hit_write) ? 4'b1111 : 4'b0000;

  bram #(
    .line_index_width(line_index_width)
  ) tag_ram (
    .clk         (clk),
    .address     (ram_address),
    .write_enable(ram_write_enable),
    .data_in     (wr_word.raw),
    .data_out    (rd_word.raw)
  );

  assign hit        = rd_word.entry.valid && rd_word.entry.tag == address_tag;
  assign dirty      = rd_word.entry.valid && rd_word.entry.dirty;
  assign victim_tag = rd_word.entry.tag;

  // refill and processor write come from different controller states
  assert property (@(posedge clk) disable iff (!rst_n) !(fill_done && hit_write));

endmodule

/* flist.f */
design/cache_pkg.sv
design/bram.sv
design/tag_store.sv
design/line_store.sv
design/burst_ctrl.sv
design/cache_top.sv
testbench/psram_model.sv
testbench/tb_cache.sv

/* run.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache \
  -f flist.f --Mdir obj_dir -o tb_cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_cache_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$log"; then
  exit 1
fi
exit 0

/* testbench/psram_model.sv */
/*
 * Behavioral 64-bit burst PSRAM for the cache testbench. Every burst is
 * four beats; reads answer after a random latency. Flags command enables
 * that come closer together than the minimum gap.
 */
`timescale 1ns/1ps

module psram_model #(
  parameter int unsigned addr_width = 21,
  parameter int unsigned min_gap = 14
) (
  input  logic                  clk,
  input  cache_pkg::br_req_t    br_req,
  input  logic [addr_width-1:0] br_addr,
  output logic [63:0]           br_rd_data,
  output logic                  br_rd_data_valid,
  output int                    error_count,
  output int                    write_bursts,
  output logic [addr_width-1:0] last_write_addr
);
  import cache_pkg::*;

  localparam int unsigned word_count = 2 ** (addr_width - 2);

  logic [31:0] mem [word_count];
  logic [31:0] byte_addr;
  int seed = 28443;
  int gap = 0;
  bit seen_cmd = 1'b0;
  int rd_wait = 0;
  int rd_beat = beat_count;
  int wr_beat = beat_count;
  int rd_base = 0;
  int wr_base = 0;

  initial begin
    br_rd_data       = '0;
    br_rd_data_valid = 1'b0;
    error_count      = 0;
    write_bursts     = 0;
    last_write_addr  = '0;
    // word at byte address a holds a * 0x9E3779B1
    for (int i = 0; i < word_count; i++) begin
      byte_addr = 32'(i * 4);
      mem[i] = byte_addr * 32'h9E3779B1;
    end
  end

  always @(posedge clk) begin
    logic [63:0] next_data;
    logic        next_valid;
    next_data  = '0;
    next_valid = 1'b0;
    gap++;
    // write beats 1 to 3 arrive on the cycles after the command
    if (wr_beat < beat_count) begin
      mem[wr_base + 2 * wr_beat]     = br_req.wr_data[31:0];
      mem[wr_base + 2 * wr_beat + 1] = br_req.wr_data[63:32];
      wr_beat++;
    end
    if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) rd_beat = 0;
    end
    if (br_req.cmd_en) begin
      if (seen_cmd && gap < min_gap) begin
        error_count++;
        $display("PSRAM model: command enable only %0d cycles after the previous one", gap);
      end
      if (br_req.data_mask != 8'h00) begin
        error_count++;
        $display("PSRAM model: nonzero data mask %h on a burst command", br_req.data_mask);
      end
      seen_cmd = 1'b1;
      gap = 0;
      if (br_req.cmd) begin
        wr_base = int'(br_addr >> 2);
        mem[wr_base]     = br_req.wr_data[31:0];
        mem[wr_base + 1] = br_req.wr_data[63:32];
        wr_beat = 1;
        write_bursts++;
        last_write_addr = br_addr;
      end else begin
        rd_base = int'(br_addr >> 2);
        rd_wait = 2 + int'($unsigned($random(seed)) % 8);
      end
    end
    if (rd_beat < beat_count) begin
      next_valid = rd_beat == 0;
      next_data  = {mem[rd_base + 2 * rd_beat + 1], mem[rd_base + 2 * rd_beat]};
      rd_beat++;
    end
    #1;
    br_rd_data       = next_data;
    br_rd_data_valid = next_valid;
  end

endmodule

/* testbench/tb_cache.sv */
/*
 * Directed testbench for the direct-mapped write-back cache. Runs reset,
 * read misses and hits, a byte-masked write, a dirty eviction and clean
 * misses against the PSRAM model, checking data, flags and bursts.
 */
`timescale 1ns/1ps

module tb_cache;
  import cache_pkg::*;

  localparam int unsigned line_index_width = 4;
  localparam int unsigned ram_addr_width = 21;
  localparam int unsigned cmd_interval = 13;
  // about 25 accesses of at most 50 cycles each plus reset and sweep
  localparam int cycle_limit = 4000;
  localparam logic [31:0] line_a = 32'h0000_1020;
  localparam logic [31:0] line_b = 32'h0000_1620;

  logic                      clk;
  logic                      rst_n;
  cpu_req_t                  req;
  logic [31:0]               data_out;
  logic                      data_out_ready;
  logic                      busy;
  br_req_t                   br_req;
  logic [ram_addr_width-1:0] br_addr;
  logic [63:0]               br_rd_data;
  logic                      br_rd_data_valid;
  int                        model_errors;
  int                        write_bursts;
  logic [ram_addr_width-1:0] last_write_addr;
  logic [31:0]               merged_value;
  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  cache_top #(
    .line_index_width(line_index_width),
    .ram_addr_width  (ram_addr_width),
    .cmd_interval    (cmd_interval)
  ) dut0 (
    .clk(clk), .rst_n(rst_n), .req(req), .data_out(data_out),
    .data_out_ready(data_out_ready), .busy(busy), .br_req(br_req), .br_addr(br_addr),
    .br_rd_data(br_rd_data), .br_rd_data_valid(br_rd_data_valid)
  );

  psram_model #(
    .addr_width(ram_addr_width),
    .min_gap   (cmd_interval + 1)
  ) psram0 (
    .clk(clk), .br_req(br_req), .br_addr(br_addr), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid), .error_count(model_errors),
    .write_bursts(write_bursts), .last_write_addr(last_write_addr)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] pattern(input logic [31:0] byte_addr);
    return byte_addr * 32'h9E3779B1;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] wen);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (wen[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // request is held until one cycle after busy is seen low
  task automatic access(input string name, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] wen,
                        input logic expect_miss, output logic [31:0] rdata);
    @(posedge clk);
    #1;
    req.en      = 1'b1;
    req.addr    = addr;
    req.wr_data = wdata;
    req.wr_en   = wen;
    // first cycle only loads the address into the RAMs
    @(negedge clk);
    @(negedge clk);
    check_flag({name, " busy"}, expect_miss, busy);
    if (!expect_miss) check_flag({name, " ready"}, wen == 4'b0000, data_out_ready);
    while (busy) @(negedge clk);
    if (expect_miss) check_flag({name, " ready after fill"}, wen == 4'b0000, data_out_ready);
    rdata = data_out;
    @(posedge clk);
    #1;
    req.en = 1'b0;
  endtask

  task automatic test_reset_sweep();
    int busy_cycles;
    busy_cycles = 0;
    @(negedge clk);
    while (busy) begin
      busy_cycles++;
      @(negedge clk);
    end
    check_word("reset sweep length", 32'd16, 32'(busy_cycles));
    repeat (3) begin
      check_flag("after sweep busy", 1'b0, busy);
      check_flag("after sweep data_out_ready", 1'b0, data_out_ready);
      check_flag("after sweep cmd_en", 1'b0, br_req.cmd_en);
      @(negedge clk);
    end
  endtask

  task automatic test_read_line();
    logic [31:0] rdata;
    access("read miss", line_a + 12, '0, 4'b0000, 1'b1, rdata);
    check_word("read miss data", pattern(line_a + 12), rdata);
    for (int k = 0; k < 8; k++) begin
      if (k != 3) begin
        access($sformatf("read hit word %0d", k), line_a + 4 * k, '0, 4'b0000, 1'b0, rdata);
        check_word($sformatf("read hit word %0d data", k), pattern(line_a + 4 * k), rdata);
      end
    end
  endtask

  task automatic test_write_hit();
    logic [31:0] rdata;
    merged_value = merge_bytes(pattern(line_a + 20), 32'hC3C3_3C3C, 4'b1010);
    access("write hit", line_a + 20, 32'hC3C3_3C3C, 4'b1010, 1'b0, rdata);
    access("read after write", line_a + 20, '0, 4'b0000, 1'b0, rdata);
    check_word("read after write data", merged_value, rdata);
  endtask

  task automatic test_eviction();
    logic [31:0] rdata;
    logic [31:0] expected;
    int bursts_before;
    bursts_before = write_bursts;
    access("conflict miss", line_b + 20, '0, 4'b0000, 1'b1, rdata);
    check_word("conflict miss data", pattern(line_b + 20), rdata);
    check_word("write burst count", 32'(bursts_before + 1), 32'(write_bursts));
    check_word("write burst address", line_a & 32'h001F_FFE0, 32'(last_write_addr));
    for (int k = 0; k < 8; k++) begin
      expected = (k == 5) ? merged_value : pattern(line_a + 4 * k);
      check_word($sformatf("evicted word %0d", k), expected, psram0.mem[(line_a >> 2) + k]);
    end
    // line b is clean so this refill writes nothing back
    access("reload evicted", line_a + 20, '0, 4'b0000, 1'b1, rdata);
    check_word("reload evicted data", merged_value, rdata);
    check_word("reload write bursts", 32'(bursts_before + 1), 32'(write_bursts));
  endtask

  task automatic test_clean_misses();
    logic [31:0] addr_list [6];
    logic [31:0] rdata;
    int bursts_before;
    addr_list = '{32'h0000_5020, 32'h0000_2040, 32'h0000_3044,
                  32'h0000_2060, 32'h0000_7FE8, 32'h0010_0104};
    bursts_before = write_bursts;
    foreach (addr_list[i]) begin
      access($sformatf("clean miss %0d", i), addr_list[i], '0, 4'b0000, 1'b1, rdata);
      check_word($sformatf("clean miss %0d data", i), pattern(addr_list[i]), rdata);
    end
    check_word("clean miss write bursts", 32'(bursts_before), 32'(write_bursts));
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    req   = '0;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_sweep();
    test_read_line();
    test_write_hit();
    test_eviction();
    test_clean_misses();
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d, model errors: %0d",
             check_count, error_count, model_errors);
    if (error_count == 0 && model_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
